// File: rv32_pipe.f
+incdir+dv
verilog/rv32_pkg.sv
verilog/rv32_decode.sv
verilog/rv32_execute.sv
verilog/rv32_result.sv
verilog/rv32_pipe.sv
dv/rv32_pipe_checker.sv
dv/rv32_pipe_tb.sv

// File: Makefile
# Verilator build and run of the rv32_pipe testbench

VERILATOR ?= verilator
TOP       ?= rv32_pipe_tb
FILELIST  ?= rv32_pipe.f
OBJ_DIR   ?= obj_dir
SIM_EXE   ?= sim_$(TOP)
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check for the pass line"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR SIM_EXE VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) -o $(SIM_EXE)
	@out="$$(./$(OBJ_DIR)/$(SIM_EXE) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "STATUS: PASS"

clean:
	rm -rf $(OBJ_DIR)

// File: dv/rv32_pipe_tb_model.svh
`ifndef RV32_PIPE_TB_MODEL_SVH
`define RV32_PIPE_TB_MODEL_SVH

logic [31:0] lfsr_state = 32'h86cdabc7;
logic [31:0] rf_m [32];
logic [31:0] mem_m [64];
wb_t         exp_wb_q [$];
longint      exp_wb_t [$];
mem_req_t    exp_req_q [$];
longint      exp_req_t [$];

// Galois LFSR stepped once per bit
function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++)
    begin
        lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ 32'h80200003 : lfsr_state >> 1;
        r = {r[30:0], lfsr_state[0]};
    end
    return r;
endfunction

function automatic logic [31:0] fill_word(input int i);
    return (i + 1) * 32'h9e3779b9;
endfunction

function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
    input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, OPC_OP};
endfunction

function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
    input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
endfunction

function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
    input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
endfunction

////////////////////////////////////////////////////////////////////////////
// Reference model in program order
////////////////////////////////////////////////////////////////////////////

function automatic void ref_step(input logic [31:0] w, input longint t);
    logic [6:0]  opc;
    logic [2:0]  f3;
    logic [4:0]  rd;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] op2;
    logic [31:0] res;
    logic [31:0] addr;
    logic [31:0] lane;
    logic [1:0]  off;
    logic [3:0]  be;
    logic        has_wb;
    wb_t         e_wb;
    mem_req_t    e_req;
    opc    = w[6:0];
    f3     = w[14:12];
    rd     = w[11:7];
    a      = (w[19:15] == 0) ? '0 : rf_m[w[19:15]];
    b      = (w[24:20] == 0) ? '0 : rf_m[w[24:20]];
    has_wb = 1'b0;
    res    = '0;
    if (opc == OPC_OP || opc == OPC_OP_IMM)
    begin
        op2    = (opc == OPC_OP) ? b : {{20{w[31]}}, w[31:20]};
        has_wb = 1'b1;
        case (f3)
            3'd0:    res = (opc == OPC_OP && w[30]) ? a - op2 : a + op2;
            3'd1:    res = a << op2[4:0];
            3'd2:    res = {31'b0, $signed(a) < $signed(op2)};
            3'd3:    res = {31'b0, a < op2};
            3'd4:    res = a ^ op2;
            3'd5:    res = w[30] ? 32'($signed(a) >>> op2[4:0]) : a >> op2[4:0];
            3'd6:    res = a | op2;
            default: res = a & op2;
        endcase
    end
    else if (opc == OPC_LOAD || opc == OPC_STORE)
    begin
        addr = a + ((opc == OPC_LOAD) ? {{20{w[31]}}, w[31:20]}
                                      : {{20{w[31]}}, w[31:25], w[11:7]});
        off  = addr[1:0];
        lane = mem_m[addr[7:2]] >> (8 * off);
        be   = 4'b0000;
        if (opc == OPC_LOAD)
        begin
            has_wb = 1'b1;
            case (f3)
                3'd0:    res = {{24{lane[7]}}, lane[7:0]};
                3'd4:    res = {24'b0, lane[7:0]};
                3'd1:    res = (off == 3) ? '0 : {{16{lane[15]}}, lane[15:0]};
                3'd5:    res = (off == 3) ? '0 : {16'b0, lane[15:0]};
                default: res = mem_m[addr[7:2]];
            endcase
        end
        else
        begin
            if (f3 == 3'd0)
                be = 4'b0001 << off;
            else if (f3 == 3'd1)
                be = (off == 3) ? 4'b0000 : 4'b0011 << off;
            else
                be = 4'b1111;
            for (int k = 0; k < 4; k++)
                if (be[k])
                    mem_m[addr[7:2]][8*k +: 8] = 8'((b << (8 * off)) >> (8 * k));
        end
        e_req.valid   = 1'b1;
        e_req.write   = (opc == OPC_STORE);
        e_req.addr    = {addr[31:2], 2'b00};
        e_req.byte_en = be;
        e_req.wdata   = (opc == OPC_STORE) ? b << (8 * off) : '0;
        exp_req_q.push_back(e_req);
        exp_req_t.push_back(t + 4 + 2);
    end
    if (has_wb && rd != 0)
    begin
        e_wb.valid = 1'b1;
        e_wb.rd    = rd;
        e_wb.data  = res;
        rf_m[rd]   = res;
        exp_wb_q.push_back(e_wb);
        exp_wb_t.push_back(t + PIPE_LATENCY * 4 + 2);
    end
endfunction

task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp)
    begin
        $display("MISMATCH %s: got %h expected %h", name, got, exp);
        $display("STATUS: FAIL");
        $fatal(1);
    end
endtask

task automatic fail_now(input string msg);
    $display("ERROR: %s", msg);
    $display("STATUS: FAIL");
    $fatal(1);
endtask

`endif

// File: dv/rv32_pipe_tb.sv
`timescale 1ns/1ps

module rv32_pipe_tb;

    import rv32_pkg::*;

    localparam int     N_DIRECTED  = 82;
    localparam int     N_RANDOM    = 300;
    localparam longint WATCHDOG_NS =
        ((N_DIRECTED + N_RANDOM) * 4 + PIPE_LATENCY + 20) * 4;

    logic            CLK = 1'b0;
    logic            rst_n;
    logic            ins_valid;
    instr_u          ins;
    logic [XLEN-1:0] mem_rdata = '0;
    mem_req_t        mem_req;
    wb_t             wb;

    logic [31:0] mem [64];
    logic [31:0] rd_addr_q;
    logic        rd_pend_q = 1'b0;
    int          edge_cnt = 0;
    int          load_edge [32];
    wb_t         e_wb;
    mem_req_t    e_req;

    `include "rv32_pipe_tb_model.svh"

    rv32_pipe uut (
        .CLK       (CLK),
        .rst_n     (rst_n),
        .ins_valid (ins_valid),
        .ins       (ins),
        .mem_rdata (mem_rdata),
        .mem_req   (mem_req),
        .wb        (wb)
    );

    always #2 CLK = ~CLK;

    ////////////////////////////////////////////////////////////////////////////
    // Memory model with read data two edges after the request
    ////////////////////////////////////////////////////////////////////////////

    always @(posedge CLK)
    begin
        rd_addr_q <= mem_req.addr;
        rd_pend_q <= mem_req.valid && !mem_req.write;
        if (rd_pend_q)
            mem_rdata <= mem[rd_addr_q[7:2]];
        if (mem_req.valid && mem_req.write)
            for (int k = 0; k < 4; k++)
                if (mem_req.byte_en[k])
                    mem[mem_req.addr[7:2]][8*k +: 8] <= mem_req.wdata[8*k +: 8];
    end

    // Compare against expected queues between edges
    always @(negedge CLK)
    begin
        if (rst_n === 1'b1 && wb.valid)
        begin
            if (exp_wb_q.size() == 0)
                fail_now("wb strobe with no instruction expecting one");
            e_wb = exp_wb_q.pop_front();
            check("wb.rd", 64'(wb.rd), 64'(e_wb.rd));
            check("wb.data", 64'(wb.data), 64'(e_wb.data));
            check("wb time", 64'($time), 64'(exp_wb_t.pop_front()));
        end
        if (rst_n === 1'b1 && mem_req.valid)
        begin
            if (exp_req_q.size() == 0)
                fail_now("mem_req strobe with no memory instruction pending");
            e_req = exp_req_q.pop_front();
            check("mem_req.write", 64'(mem_req.write), 64'(e_req.write));
            check("mem_req.addr", 64'(mem_req.addr), 64'(e_req.addr));
            check("mem_req.byte_en", 64'(mem_req.byte_en), 64'(e_req.byte_en));
            check("mem_req.wdata", 64'(mem_req.wdata), 64'(e_req.wdata));
            check("mem_req time", 64'($time), 64'(exp_req_t.pop_front()));
        end
    end

    task automatic issue(input logic [31:0] w);
        @(posedge CLK);
        edge_cnt++;
        ins_valid <= 1'b1;
        ins       <= w;
        ref_step(w, $time + 4);
        if (w[11:7] != 0 && w[6:0] == OPC_LOAD)
            load_edge[w[11:7]] = edge_cnt;
        else if (w[11:7] != 0 && (w[6:0] == OPC_OP || w[6:0] == OPC_OP_IMM))
            load_edge[w[11:7]] = -100;
    endtask

    task automatic idle(input int n);
        repeat (n)
        begin
            @(posedge CLK);
            edge_cnt++;
            ins_valid <= 1'b0;
        end
    endtask

    // Source register that keeps the load-use distance
    function automatic logic [4:0] pick_src();
        logic [4:0] r;
        r = 5'(rand_bits(5));
        if (edge_cnt + 1 - load_edge[r] < PIPE_LATENCY)
            r = '0;
        return r;
    endfunction

    function automatic logic [2:0] load_f3(input int k);
        case (k % 5)
            0:       return 3'd0;
            1:       return 3'd1;
            2:       return 3'd2;
            3:       return 3'd4;
            default: return 3'd5;
        endcase
    endfunction

    task automatic run_random(input int n);
        logic [2:0]  kind;
        logic [2:0]  f3;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [11:0] imm;
        logic [31:0] w;
        for (int i = 0; i < n; i++)
        begin
            kind = 3'(rand_bits(3));
            f3   = 3'(rand_bits(3));
            rd   = 5'(rand_bits(5));
            rs1  = pick_src();
            rs2  = pick_src();
            imm  = 12'(rand_bits(12));
            case (kind)
                3'd0, 3'd1: w = enc_r({1'b0, rand_bits(1) == 1, 5'b0}, rs2, rs1, f3, rd);
                3'd2, 3'd3: w = enc_i(imm, rs1, f3, rd, OPC_OP_IMM);
                3'd4:       w = enc_i(imm, rs1, load_f3(int'(f3)), rd, OPC_LOAD);
                3'd5:       w = enc_s(imm, rs2, rs1, 3'(f3 % 3));
                3'd6:       w = {25'(rand_bits(25)), 7'b1100011};
                default:    w = enc_r(7'h00, rs2, rs1, f3, 5'd0);
            endcase
            issue(w);
            if (rand_bits(2) == 0)
                idle(rand_bits(2));
        end
    endtask

    initial
    begin
        rst_n     <= 1'b0;
        ins_valid <= 1'b0;
        ins       <= '0;
        for (int i = 0; i < 64; i++)
        begin
            mem[i]   <= fill_word(i);
            mem_m[i]  = fill_word(i);
        end
        for (int i = 0; i < 32; i++)
        begin
            rf_m[i]      = '0;
            load_edge[i] = -100;
        end
        repeat (3) @(posedge CLK);
        rst_n <= 1'b1;

        for (int r = 1; r < 32; r++)
            issue(enc_i(12'(rand_bits(12)), 5'd0, 3'd0, 5'(r), OPC_OP_IMM));

        // Dependent chain forwarding from every stage
        issue(enc_r(7'h00, 5'd1, 5'd1, 3'd0, 5'd2));
        issue(enc_r(7'h20, 5'd1, 5'd2, 3'd0, 5'd3));
        issue(enc_r(7'h00, 5'd2, 5'd3, 3'd4, 5'd4));
        issue(enc_r(7'h00, 5'd3, 5'd4, 3'd1, 5'd4));
        issue(enc_r(7'h20, 5'd2, 5'd4, 3'd5, 5'd5));
        issue(enc_r(7'h00, 5'd4, 5'd5, 3'd2, 5'd6));
        issue(enc_r(7'h00, 5'd4, 5'd5, 3'd3, 5'd7));
        issue(enc_r(7'h00, 5'd5, 5'd4, 3'd7, 5'd8));
        issue(enc_r(7'h00, 5'd8, 5'd4, 3'd6, 5'd9));
        issue(enc_r(7'h00, 5'd2, 5'd9, 3'd5, 5'd9));

        // Negative immediates and both right shifts
        issue(enc_i(12'hc18, 5'd0, 3'd0, 5'd15, OPC_OP_IMM));
        issue(enc_i({7'h20, 5'd4}, 5'd15, 3'd5, 5'd16, OPC_OP_IMM));
        issue(enc_i({7'h00, 5'd4}, 5'd15, 3'd5, 5'd17, OPC_OP_IMM));
        issue(enc_i(12'h005, 5'd15, 3'd2, 5'd18, OPC_OP_IMM));
        issue(enc_i(12'h005, 5'd15, 3'd3, 5'd19, OPC_OP_IMM));

        for (int f = 0; f < 3; f++)
            for (int off = 0; off < 4; off++)
                issue(enc_s(12'(64 + 16 * f + 5 * off), 5'd4, 5'd0, 3'(f)));
        for (int k = 0; k < 20; k++)
            issue(enc_i(12'(64 + 16 * (k % 3) + 5 * (k % 4)), 5'd0, load_f3(k),
                        5'(10 + k % 4), OPC_LOAD));

        // Unsupported opcode, rd zero, then x0 as a source
        issue({25'h1abcde5, 7'b1100011});
        issue(enc_i(12'h007, 5'd5, 3'd0, 5'd0, OPC_OP_IMM));
        issue(enc_r(7'h00, 5'd0, 5'd0, 3'd6, 5'd20));
        issue(enc_r(7'h00, 5'd5, 5'd0, 3'd0, 5'd21));
        idle(2);

        run_random(N_RANDOM);
        idle(PIPE_LATENCY + 4);

        if (exp_wb_q.size() != 0 || exp_req_q.size() != 0)
        begin
            fail_now("expected strobes never arrived");
        end
        else
        begin
            $display("STATUS: PASS");
            $finish;
        end
    end

    initial
    begin
        #(WATCHDOG_NS);
        fail_now("watchdog timeout, run did not finish");
    end

endmodule

// File: dv/rv32_pipe_checker.sv
`timescale 1ns/1ps

module rv32_pipe_checker (
    input logic               CLK,
    input logic               rst_n,
    input logic               ins_valid,
    input rv32_pkg::mem_req_t mem_req,
    input rv32_pkg::wb_t      wb
);

    import rv32_pkg::*;

    // Sampled one edge after the output register loads
    a_wb_timing: assert property (@(posedge CLK) disable iff (!rst_n)
        wb.valid |-> $past(ins_valid, PIPE_LATENCY + 1))
        else $error("wb strobe without an instruction accepted 4 cycles before");

    a_req_timing: assert property (@(posedge CLK) disable iff (!rst_n)
        mem_req.valid |-> $past(ins_valid, 2))
        else $error("mem_req strobe without an instruction accepted 1 cycle before");

    a_wb_rd: assert property (@(posedge CLK) disable iff (!rst_n)
        wb.valid |-> wb.rd != '0)
        else $error("wb strobe with rd zero");

    a_reset: assert property (@(posedge CLK)
        !rst_n |-> !wb.valid && !mem_req.valid)
        else $error("valid output high during reset");

endmodule

bind rv32_pipe rv32_pipe_checker u_checker (
    .CLK       (CLK),
    .rst_n     (rst_n),
    .ins_valid (ins_valid),
    .mem_req   (mem_req),
    .wb        (wb)
);

// File: verilog/rv32_pipe.sv
`timescale 1ns/1ps

module rv32_pipe (
    input  logic                      CLK,
    input  logic                      rst_n,
    input  logic                      ins_valid,
    input  rv32_pkg::instr_u          ins,
    input  logic [rv32_pkg::XLEN-1:0] mem_rdata,
    output rv32_pkg::mem_req_t        mem_req,
    output rv32_pkg::wb_t             wb
);

    import rv32_pkg::*;

    dec_ex_t dec;
    ex_res_t res;
    ex_res_t fwd_stages [LOAD_LATENCY];

    rv32_decode u_decode (
        .CLK       (CLK),
        .rst_n     (rst_n),
        .ins_valid (ins_valid),
        .ins       (ins),
        .wb        (wb),
        .dec       (dec)
    );

    rv32_execute u_execute (
        .CLK        (CLK),
        .rst_n      (rst_n),
        .dec        (dec),
        .fwd_stages (fwd_stages),
        .wb         (wb),
        .res        (res),
        .mem_req    (mem_req)
    );

    // Wait stages feed forwarding back into execute
    rv32_result u_result (
        .CLK        (CLK),
        .rst_n      (rst_n),
        .res        (res),
        .mem_rdata  (mem_rdata),
        .fwd_stages (fwd_stages),
        .wb         (wb)
    );

endmodule

// File: verilog/rv32_result.sv
`timescale 1ns/1ps

module rv32_result (
    input  logic                      CLK,
    input  logic                      rst_n,
    input  rv32_pkg::ex_res_t         res,
    input  logic [rv32_pkg::XLEN-1:0] mem_rdata,
    output rv32_pkg::ex_res_t         fwd_stages [rv32_pkg::LOAD_LATENCY],
    output rv32_pkg::wb_t             wb
);

    import rv32_pkg::*;

    ex_res_t         last;
    logic [1:0]      offset;
    logic [XLEN-1:0] lane;
    logic [XLEN-1:0] load_val;
    wb_t             wb_d;

    ////////////////////////////////////////////////////////////////////////////
    // Memory wait stages
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge CLK or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < LOAD_LATENCY; i++)
                fwd_stages[i].valid <= 1'b0;
        end
        else
        begin
            fwd_stages[0] <= res;
            for (int i = 1; i < LOAD_LATENCY; i++)
                fwd_stages[i] <= fwd_stages[i-1];
        end
    end

    // Load lane extraction
    always_comb
    begin
        last   = fwd_stages[LOAD_LATENCY-1];
        offset = last.result[1:0];
        lane   = mem_rdata >> {offset, 3'b000};
        case (last.mem_op)
            MEM_B:   load_val = {{(XLEN-8){lane[7]}}, lane[7:0]};
            MEM_BU:  load_val = {{(XLEN-8){1'b0}}, lane[7:0]};
            MEM_H:
            begin
                if (offset == 2'd3)
                    load_val = '0;
                else
                    load_val = {{(XLEN-16){lane[15]}}, lane[15:0]};
            end
            MEM_HU:
            begin
                if (offset == 2'd3)
                    load_val = '0;
                else
                    load_val = {{(XLEN-16){1'b0}}, lane[15:0]};
            end
            default: load_val = mem_rdata;
        endcase

        // Nothing written back for x0
        wb_d.valid = last.valid && last.rd != '0;
        wb_d.rd    = last.rd;
        wb_d.data  = last.is_load ? load_val : last.result;
    end

    always_ff @(posedge CLK or negedge rst_n)
    begin
        if (!rst_n)
            wb.valid <= 1'b0;
        else
            wb <= wb_d;
    end

endmodule

// File: verilog/rv32_execute.sv
`timescale 1ns/1ps

module rv32_execute (
    input  logic               CLK,
    input  logic               rst_n,
    input  rv32_pkg::dec_ex_t  dec,
    input  rv32_pkg::ex_res_t  fwd_stages [rv32_pkg::LOAD_LATENCY],
    input  rv32_pkg::wb_t      wb,
    output rv32_pkg::ex_res_t  res,
    output rv32_pkg::mem_req_t mem_req
);

    import rv32_pkg::*;

    ex_res_t         fwd_src [LOAD_LATENCY+2];
    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] rs2_fwd;
    logic [XLEN-1:0] op_b;
    logic [4:0]      shamt;
    logic [XLEN-1:0] alu_out;
    logic [1:0]      offset;
    logic [3:0]      byte_en;
    ex_res_t         res_d;
    mem_req_t        req_d;

    ////////////////////////////////////////////////////////////////////////////
    // Forwarding, newest entry at index 0
    ////////////////////////////////////////////////////////////////////////////

    always_comb
    begin
        fwd_src[0] = res;
        for (int i = 0; i < LOAD_LATENCY; i++)
            fwd_src[i+1] = fwd_stages[i];
        // Load data is final by writeback
        fwd_src[LOAD_LATENCY+1].valid   = wb.valid;
        fwd_src[LOAD_LATENCY+1].is_load = 1'b0;
        fwd_src[LOAD_LATENCY+1].mem_op  = MEM_W;
        fwd_src[LOAD_LATENCY+1].rd      = wb.rd;
        fwd_src[LOAD_LATENCY+1].result  = wb.data;
    end

    always_comb
    begin
        op_a    = dec.rs1_val;
        rs2_fwd = dec.rs2_val;
        for (int i = LOAD_LATENCY + 1; i >= 0; i--)
        begin
            if (fwd_src[i].valid && !fwd_src[i].is_load && fwd_src[i].rd != '0)
            begin
                if (fwd_src[i].rd == dec.rs1)
                    op_a = fwd_src[i].result;
                if (fwd_src[i].rd == dec.rs2)
                    rs2_fwd = fwd_src[i].result;
            end
        end
        op_b = dec.use_imm ? dec.imm : rs2_fwd;
    end

    // ALU, also base plus offset for memory ops
    always_comb
    begin
        shamt = op_b[4:0];
        case (dec.alu_op)
            ALU_SUB:  alu_out = op_a - op_b;
            ALU_AND:  alu_out = op_a & op_b;
            ALU_OR:   alu_out = op_a | op_b;
            ALU_XOR:  alu_out = op_a ^ op_b;
            ALU_SLT:  alu_out = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            ALU_SLTU: alu_out = {{(XLEN-1){1'b0}}, op_a < op_b};
            ALU_SLL:  alu_out = op_a << shamt;
            ALU_SRL:  alu_out = op_a >> shamt;
            ALU_SRA:  alu_out = $signed(op_a) >>> shamt;
            default:  alu_out = op_a + op_b;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // Memory request
    ////////////////////////////////////////////////////////////////////////////

    always_comb
    begin
        offset  = alu_out[1:0];
        byte_en = 4'b0000;
        if (dec.is_store)
        begin
            case (dec.mem_op)
                MEM_B:   byte_en = 4'b0001 << offset;
                // Halfword across the word boundary writes nothing
                MEM_H:   byte_en = (offset == 2'd3) ? 4'b0000 : 4'b0011 << offset;
                MEM_W:   byte_en = 4'b1111;
                default: byte_en = 4'b0000;
            endcase
        end
        req_d.valid   = dec.valid && (dec.is_load || dec.is_store);
        req_d.write   = dec.is_store;
        req_d.addr    = {alu_out[XLEN-1:2], 2'b00};
        req_d.byte_en = byte_en;
        req_d.wdata   = dec.is_store ? rs2_fwd << {offset, 3'b000} : '0;

        res_d.valid   = dec.valid;
        res_d.is_load = dec.is_load;
        res_d.mem_op  = dec.mem_op;
        res_d.rd      = dec.rd;
        res_d.result  = alu_out;
    end

    always_ff @(posedge CLK or negedge rst_n)
    begin
        if (!rst_n)
        begin
            res.valid     <= 1'b0;
            mem_req.valid <= 1'b0;
        end
        else
        begin
            res     <= res_d;
            mem_req <= req_d;
        end
    end

endmodule

// File: verilog/rv32_decode.sv
`timescale 1ns/1ps

module rv32_decode (
    input  logic              CLK,
    input  logic              rst_n,
    input  logic              ins_valid,
    input  rv32_pkg::instr_u  ins,
    input  rv32_pkg::wb_t     wb,
    output rv32_pkg::dec_ex_t dec
);

    import rv32_pkg::*;

    logic [XLEN-1:0] rf [1:2**REG_ADDR_W-1];
    logic [XLEN-1:0] rs1_val;
    logic [XLEN-1:0] rs2_val;
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_s;
    logic            supported;
    dec_ex_t         dec_d;

    function automatic alu_op_e alu_from_funct3(
        input logic [2:0] funct3,
        input logic       alt_sub,
        input logic       alt_sra
    );
        case (funct3)
            3'b000:  return alt_sub ? ALU_SUB : ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b011:  return ALU_SLTU;
            3'b100:  return ALU_XOR;
            3'b101:  return alt_sra ? ALU_SRA : ALU_SRL;
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    // Register read, bypassing a write in the same cycle
    always_comb
    begin
        rs1_val = '0;
        rs2_val = '0;
        if (ins.r_fmt.rs1 != '0)
            rs1_val = (wb.valid && wb.rd == ins.r_fmt.rs1) ? wb.data : rf[ins.r_fmt.rs1];
        if (ins.r_fmt.rs2 != '0)
            rs2_val = (wb.valid && wb.rd == ins.r_fmt.rs2) ? wb.data : rf[ins.r_fmt.rs2];
    end

    always_comb
    begin
        imm_i     = {{(XLEN-12){ins.r_fmt.funct7[6]}}, ins.r_fmt.funct7, ins.r_fmt.rs2};
        imm_s     = {{(XLEN-12){ins.s_fmt.imm_hi[6]}}, ins.s_fmt.imm_hi, ins.s_fmt.imm_lo};
        supported = 1'b0;
        dec_d         = '0;
        dec_d.alu_op  = ALU_ADD;
        dec_d.mem_op  = MEM_W;
        dec_d.rs1     = ins.r_fmt.rs1;
        dec_d.rs1_val = rs1_val;
        case (ins.r_fmt.opcode)
            OPC_OP:
            begin
                supported     = 1'b1;
                dec_d.alu_op  = alu_from_funct3(ins.r_fmt.funct3, ins.r_fmt.funct7[5],
                                                ins.r_fmt.funct7[5]);
                dec_d.rd      = ins.r_fmt.rd;
                dec_d.rs2     = ins.r_fmt.rs2;
                dec_d.rs2_val = rs2_val;
            end
            OPC_OP_IMM:
            begin
                // No SUBI, bit 30 only picks SRAI
                supported     = 1'b1;
                dec_d.alu_op  = alu_from_funct3(ins.r_fmt.funct3, 1'b0, ins.r_fmt.funct7[5]);
                dec_d.use_imm = 1'b1;
                dec_d.imm     = imm_i;
                dec_d.rd      = ins.r_fmt.rd;
            end
            OPC_LOAD:
            begin
                supported     = 1'b1;
                dec_d.is_load = 1'b1;
                dec_d.use_imm = 1'b1;
                dec_d.imm     = imm_i;
                dec_d.rd      = ins.r_fmt.rd;
                case (ins.r_fmt.funct3)
                    3'b000:  dec_d.mem_op = MEM_B;
                    3'b001:  dec_d.mem_op = MEM_H;
                    3'b010:  dec_d.mem_op = MEM_W;
                    3'b100:  dec_d.mem_op = MEM_BU;
                    3'b101:  dec_d.mem_op = MEM_HU;
                    default: supported = 1'b0;
                endcase
            end
            OPC_STORE:
            begin
                supported      = 1'b1;
                dec_d.is_store = 1'b1;
                dec_d.use_imm  = 1'b1;
                dec_d.imm      = imm_s;
                dec_d.rs2      = ins.s_fmt.rs2;
                dec_d.rs2_val  = rs2_val;
                case (ins.s_fmt.funct3)
                    3'b000:  dec_d.mem_op = MEM_B;
                    3'b001:  dec_d.mem_op = MEM_H;
                    3'b010:  dec_d.mem_op = MEM_W;
                    default: supported = 1'b0;
                endcase
            end
            default:
            begin
                supported = 1'b0;
            end
        endcase
        dec_d.valid = ins_valid && supported;
    end

    always_ff @(posedge CLK)
    begin
        if (wb.valid && wb.rd != '0)
            rf[wb.rd] <= wb.data;
    end

    always_ff @(posedge CLK or negedge rst_n)
    begin
        if (!rst_n)
            dec.valid <= 1'b0;
        else
            dec <= dec_d;
    end

endmodule

// File: verilog/rv32_pkg.sv
package rv32_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Widths and latencies
    ////////////////////////////////////////////////////////////////////////////

    localparam int XLEN         = 32;
    localparam int REG_ADDR_W   = 5;
    localparam int LOAD_LATENCY = 2;
    // Accepting edge to writeback edge
    localparam int PIPE_LATENCY = 4;

    // Major opcodes
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA
    } alu_op_e;

    // Same code as funct3 of loads and stores
    typedef enum logic [2:0] {
        MEM_B  = 3'b000,
        MEM_H  = 3'b001,
        MEM_W  = 3'b010,
        MEM_BU = 3'b100,
        MEM_HU = 3'b101
    } mem_op_e;

    ////////////////////////////////////////////////////////////////////////////
    // Instruction word
    ////////////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic [6:0]            funct7;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [6:0]            imm_hi;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [4:0]            imm_lo;
        logic [6:0]            opcode;
    } s_fmt_t;

    // I-type fields come through r_fmt
    typedef union packed {
        r_fmt_t r_fmt;
        s_fmt_t s_fmt;
    } instr_u;

    ////////////////////////////////////////////////////////////////////////////
    // Stage bundles
    ////////////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic                  valid;
        alu_op_e               alu_op;
        mem_op_e               mem_op;
        logic                  is_load;
        logic                  is_store;
        logic                  use_imm;
        logic [REG_ADDR_W-1:0] rd;
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        logic [XLEN-1:0]       rs1_val;
        logic [XLEN-1:0]       rs2_val;
        logic [XLEN-1:0]       imm;
    } dec_ex_t;

    // result is the full address for loads
    typedef struct packed {
        logic                  valid;
        logic                  is_load;
        mem_op_e               mem_op;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       result;
    } ex_res_t;

    typedef struct packed {
        logic            valid;
        logic            write;
        logic [XLEN-1:0] addr;
        logic [3:0]      byte_en;
        logic [XLEN-1:0] wdata;
    } mem_req_t;

    typedef struct packed {
        logic                  valid;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       data;
    } wb_t;

endpackage
